/* rtl/fetch_pkg.sv */
package fetch_pkg;

    typedef logic [31:0] instr_t;  // one full instruction word as read from memory.

    typedef logic [31:0] addr_t;   // byte address or program counter.

    typedef logic [15:0] half_t;   // one parcel of the halfword stream.

    // states of the bundle fetcher FSM.
    typedef enum logic [1:0] {
        FETCH_IDLE     = 2'd0,     // no read in flight and no bundle held.
        FETCH_WAIT_MEM = 2'd1,     // a read is outstanding and its data will be kept.
        FETCH_HOLD     = 2'd2,     // a bundle is held until the buffer runs empty.
        FETCH_DROP     = 2'd3      // a read is outstanding but a flush made its data stale.
    } fetch_state_e;

    // length of the instruction at the head of the buffer.
    typedef enum logic {
        LEN_16 = 1'b0,             // compressed instruction of one halfword.
        LEN_32 = 1'b1              // standard instruction of two halfwords.
    } instr_len_e;

endpackage : fetch_pkg

/* rtl/fetch_bundle_if.sv */
`timescale 1ns/10ps

interface fetch_bundle_if #(
    parameter int BUFFER_SIZE = 8                       // bundle width in 32-bit words.
);
    import fetch_pkg::*;

    localparam int SIZE_W = $clog2(2 * BUFFER_SIZE) + 1; // enough bits to count a full bundle.

    instr_t [BUFFER_SIZE-1:0] bundle;        // word i sits at the bundle base plus 4*i.
    logic   [SIZE_W-1:0]      bundle_size;   // number of valid halfwords in the bundle.
    logic                     load;          // one-cycle strobe that copies the bundle.
    logic                     request;       // level that asks the fetcher for more data.

    modport fetcher (
        output bundle,
        output bundle_size,
        output load,
        input  request
    );

    modport buffer (
        input  bundle,
        input  bundle_size,
        input  load,
        output request
    );

endinterface : fetch_bundle_if

/* rtl/bundle_fetcher.sv */
`timescale 1ns/10ps

module bundle_fetcher #(
    parameter int               BUFFER_SIZE = 8,             // bundle width in 32-bit words.
    parameter fetch_pkg::addr_t BOOT_PC     = 32'h0000_0000  // must sit on a bundle boundary.
) (
    input  logic                                clk_i,
    input  logic                                rst_n_i,
    input  logic                                flush_i,
    input  fetch_pkg::addr_t                    redirect_pc_i,
    input  logic                                buffer_empty_i,
    fetch_bundle_if.fetcher                     bundle_if,
    output logic                                mem_req_o,
    output fetch_pkg::addr_t                    mem_addr_o,
    input  logic                                mem_valid_i,
    input  fetch_pkg::instr_t [BUFFER_SIZE-1:0] mem_bundle_i
);
    import fetch_pkg::*;

    localparam int ALIGN_W = $clog2(4 * BUFFER_SIZE);     // byte offset bits inside a bundle.
    localparam int OFFS_W  = ALIGN_W - 1;                 // halfword offset bits inside a bundle.
    localparam int SIZE_W  = $clog2(2 * BUFFER_SIZE) + 1; // matches bundle_size in the interface.

    fetch_state_e             state;
    fetch_state_e             state_next;
    addr_t                    fetch_addr;     // bundle aligned address of the next read.
    logic [OFFS_W-1:0]        head_offset;    // halfwords to skip in the next bundle loaded.
    instr_t [BUFFER_SIZE-1:0] hold_bundle;    // prefetched bundle waiting for an empty buffer.
    logic                     read_pending;   // tracks the memory handshake on its own.

    assign mem_req_o  = rst_n_i && (state == FETCH_IDLE) && bundle_if.request
                        && !flush_i;         // no reads during reset, and a flush retargets first.
    assign mem_addr_o = fetch_addr;          // the address only changes on flush or load.

    assign bundle_if.load        = (state == FETCH_HOLD) && buffer_empty_i && !flush_i;
    assign bundle_if.bundle      = hold_bundle >> (head_offset * 16); // redirect halfword goes to word 0.
    assign bundle_if.bundle_size = SIZE_W'(2 * BUFFER_SIZE) - SIZE_W'(head_offset);

    always_comb begin : next_state_logic
        state_next = state;
        case (state)
            FETCH_IDLE: begin
                if (mem_req_o) begin
                    state_next = FETCH_WAIT_MEM;        // one read goes out this cycle.
                end
            end
            FETCH_WAIT_MEM: begin
                if (mem_valid_i) begin
                    state_next = flush_i ? FETCH_IDLE : FETCH_HOLD; // stale data is not kept.
                end else if (flush_i) begin
                    state_next = FETCH_DROP;            // the reply must still be swallowed.
                end
            end
            FETCH_HOLD: begin
                if (flush_i || bundle_if.load) begin
                    state_next = FETCH_IDLE;            // the held bundle is used or discarded.
                end
            end
            FETCH_DROP: begin
                if (mem_valid_i) begin
                    state_next = FETCH_IDLE;
                end
            end
            default: begin
                state_next = FETCH_IDLE;
            end
        endcase
    end : next_state_logic

    always_ff @(posedge clk_i) begin : state_register
        if (!rst_n_i) begin
            state <= FETCH_IDLE;
        end else begin
            state <= state_next;
        end
    end : state_register

    always_ff @(posedge clk_i) begin : address_register
        if (!rst_n_i) begin
            fetch_addr  <= BOOT_PC;
            head_offset <= '0;
        end else if (flush_i) begin
            fetch_addr  <= {redirect_pc_i[31:ALIGN_W], ALIGN_W'(0)}; // restart on the enclosing bundle.
            head_offset <= redirect_pc_i[ALIGN_W-1:1];               // skip the halfwords before the target.
        end else if (bundle_if.load) begin
            fetch_addr  <= fetch_addr + addr_t'(4 * BUFFER_SIZE);    // move to the next bundle boundary.
            head_offset <= '0;                                       // later bundles start at word 0.
        end
    end : address_register

    always_ff @(posedge clk_i) begin : hold_register
        if ((state == FETCH_WAIT_MEM) && mem_valid_i) begin
            hold_bundle <= mem_bundle_i;
        end
    end : hold_register

    always_ff @(posedge clk_i) begin : pending_tracker
        if (!rst_n_i) begin
            read_pending <= 1'b0;
        end else if (mem_req_o) begin
            read_pending <= 1'b1;
        end else if (mem_valid_i) begin
            read_pending <= 1'b0;
        end
    end : pending_tracker

    // a load must leave the buffer holding data.
    load_fills_buffer: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        bundle_if.load |=> !buffer_empty_i)
        else $error("bundle load left the instruction buffer empty.");

    single_read: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        mem_req_o |-> !read_pending)
        else $error("memory read issued while another read is outstanding.");

endmodule : bundle_fetcher

/* rtl/instruction_buffer.sv */
`timescale 1ns/10ps

module instruction_buffer #(
    parameter int BUFFER_SIZE   = 8,   // bundle width in 32-bit words.
    parameter int REQUEST_LIMIT = 4    // halfword count below which a prefetch is asked for.
) (
    input  logic              clk_i,
    input  logic              rst_n_i,
    input  logic              flush_i,
    input  logic              consume_i,
    input  logic              compressed_i,
    fetch_bundle_if.buffer    bundle_if,
    output fetch_pkg::instr_t head_window_o,
    output logic              buffer_empty_o
);
    import fetch_pkg::*;

    localparam int HALVES = 2 * BUFFER_SIZE;          // halfword slots in the stream.
    localparam int SIZE_W = $clog2(HALVES) + 1;       // one more bit so a full bundle fits.

    logic  [SIZE_W-1:0]   buffer_size;   // valid halfwords left, compressed parcels count once.
    half_t [HALVES-1:0]   stream;        // the head halfword lives in the top slot.

    always_ff @(posedge clk_i) begin : size_counter
        if (!rst_n_i) begin
            buffer_size <= '0;
        end else if (flush_i) begin
            buffer_size <= '0;                          // everything ahead of the redirect is stale.
        end else if (bundle_if.load) begin
            buffer_size <= bundle_if.bundle_size;       // the fetcher already removed skipped halves.
        end else if (consume_i && (buffer_size != '0)) begin
            if (compressed_i) begin
                buffer_size <= buffer_size - SIZE_W'(1);
            end else if (buffer_size == SIZE_W'(1)) begin
                buffer_size <= '0;                      // saturate instead of wrapping around.
            end else begin
                buffer_size <= buffer_size - SIZE_W'(2);
            end
        end
    end : size_counter

    assign buffer_empty_o    = (buffer_size == '0);
    assign bundle_if.request = (buffer_size < SIZE_W'(REQUEST_LIMIT)); // start the next read early.

    always_ff @(posedge clk_i) begin : stream_storage
        if (bundle_if.load) begin
            for (int i = 0; i < BUFFER_SIZE; i++) begin
                stream[HALVES-1-2*i] <= bundle_if.bundle[i][15:0];  // low half comes first in memory.
                stream[HALVES-2-2*i] <= bundle_if.bundle[i][31:16];
            end
        end else if (consume_i) begin
            if (compressed_i) begin
                stream <= {stream[HALVES-2:0], 16'h0000};  // drop one parcel from the head.
            end else begin
                stream <= {stream[HALVES-3:0], 32'h0000_0000}; // drop two parcels from the head.
            end
        end
    end : stream_storage

    // first parcel in the low half so the window reads like a memory word.
    assign head_window_o = {stream[HALVES-2], stream[HALVES-1]};

    no_consume_when_empty: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        consume_i |-> !buffer_empty_o)
        else $error("instruction consumed from an empty buffer.");

endmodule : instruction_buffer

/* rtl/instr_length_decoder.sv */
`timescale 1ns/10ps

module instr_length_decoder #(
    parameter fetch_pkg::addr_t BOOT_PC = 32'h0000_0000  // program counter after reset.
) (
    input  logic              clk_i,
    input  logic              rst_n_i,
    input  logic              flush_i,
    input  fetch_pkg::addr_t  redirect_pc_i,
    input  logic              stall_i,
    input  fetch_pkg::instr_t head_window_i,
    input  logic              buffer_empty_i,
    output logic              compressed_o,
    output logic              consume_o,
    output fetch_pkg::instr_t instr_o,
    output fetch_pkg::addr_t  pc_o,
    output logic              instr_valid_o
);
    import fetch_pkg::*;

    half_t      first_half;   // lowest parcel of the instruction at the head.
    instr_len_e instr_len;
    addr_t      pc_q;

    assign first_half = head_window_i[15:0];
    assign instr_len  = (first_half[1:0] == 2'b11) ? LEN_32 : LEN_16; // 11 marks a 32-bit opcode.

    assign compressed_o  = (instr_len == LEN_16);
    assign instr_valid_o = !buffer_empty_i;              // any parcel at the head is an instruction.
    assign consume_o     = instr_valid_o && !stall_i;    // the consumer takes it on this edge.

    always_comb begin : instr_select
        if (instr_len == LEN_32) begin
            instr_o = head_window_i;
        end else begin
            instr_o = {16'h0000, first_half};            // compressed parcels leave zero-extended.
        end
    end : instr_select

    always_ff @(posedge clk_i) begin : pc_register
        if (!rst_n_i) begin
            pc_q <= BOOT_PC;
        end else if (flush_i) begin
            pc_q <= redirect_pc_i;                       // the next instruction starts here.
        end else if (consume_o) begin
            if (instr_len == LEN_32) begin
                pc_q <= pc_q + addr_t'(4);
            end else begin
                pc_q <= pc_q + addr_t'(2);
            end
        end
    end : pc_register

    assign pc_o = pc_q;

endmodule : instr_length_decoder

/* rtl/fetch_unit.sv */
`timescale 1ns/10ps

module fetch_unit #(
    parameter int               BUFFER_SIZE   = 8,             // bundle width in 32-bit words.
    parameter int               REQUEST_LIMIT = 4,             // prefetch threshold in halfwords.
    parameter fetch_pkg::addr_t BOOT_PC       = 32'h0000_0000  // bundle aligned reset address.
) (
    input  logic                                clk_i,
    input  logic                                rst_n_i,
    input  logic                                stall_i,
    input  logic                                flush_i,
    input  fetch_pkg::addr_t                    redirect_pc_i,
    output logic                                mem_req_o,
    output fetch_pkg::addr_t                    mem_addr_o,
    input  logic                                mem_valid_i,
    input  fetch_pkg::instr_t [BUFFER_SIZE-1:0] mem_bundle_i,
    output fetch_pkg::instr_t                   instr_o,
    output fetch_pkg::addr_t                    pc_o,
    output logic                                instr_valid_o
);
    import fetch_pkg::*;

    logic   buffer_empty;   // shared by the fetcher and the decoder.
    instr_t head_window;
    logic   compressed;
    logic   consume;

    fetch_bundle_if #(.BUFFER_SIZE(BUFFER_SIZE)) bundle_if ();

    bundle_fetcher #(
        .BUFFER_SIZE    (BUFFER_SIZE),
        .BOOT_PC        (BOOT_PC)
    ) u_bundle_fetcher (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .flush_i        (flush_i),
        .redirect_pc_i  (redirect_pc_i),
        .buffer_empty_i (buffer_empty),
        .bundle_if      (bundle_if.fetcher),
        .mem_req_o      (mem_req_o),
        .mem_addr_o     (mem_addr_o),
        .mem_valid_i    (mem_valid_i),
        .mem_bundle_i   (mem_bundle_i)
    );

    instruction_buffer #(
        .BUFFER_SIZE    (BUFFER_SIZE),
        .REQUEST_LIMIT  (REQUEST_LIMIT)
    ) u_instruction_buffer (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .flush_i        (flush_i),
        .consume_i      (consume),
        .compressed_i   (compressed),
        .bundle_if      (bundle_if.buffer),
        .head_window_o  (head_window),
        .buffer_empty_o (buffer_empty)
    );

    instr_length_decoder #(
        .BOOT_PC        (BOOT_PC)
    ) u_instr_length_decoder (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .flush_i        (flush_i),
        .redirect_pc_i  (redirect_pc_i),
        .stall_i        (stall_i),
        .head_window_i  (head_window),
        .buffer_empty_i (buffer_empty),
        .compressed_o   (compressed),
        .consume_o      (consume),
        .instr_o        (instr_o),
        .pc_o           (pc_o),
        .instr_valid_o  (instr_valid_o)
    );

endmodule : fetch_unit

/* verif/fetch_checker.sv */
`timescale 1ns/10ps

module fetch_checker #(
    parameter fetch_pkg::addr_t BOOT_PC = 32'h0000_0000,  // first fetch address after reset.
    parameter int               MAX_EXP = 64              // room in the expected stream.
) (
    input  logic              clk_i,
    input  logic              rst_n_i,
    input  logic              stall_i,
    input  logic              flush_i,
    input  logic              instr_valid_i,
    input  fetch_pkg::instr_t instr_i,
    input  fetch_pkg::addr_t  pc_i,
    input  logic              mem_req_i,
    input  fetch_pkg::addr_t  mem_addr_i,
    input  fetch_pkg::addr_t  exp_pc_i [MAX_EXP],
    input  fetch_pkg::instr_t exp_instr_i [MAX_EXP],
    input  int                exp_test_i [MAX_EXP],
    input  int                exp_count_i,
    output int                accepted_o,
    output int                mismatch_count_o,
    output int                failure_count_o
);
    import fetch_pkg::*;

    bit seen_edge;        // reset has been applied by at least one clock edge.
    bit first_req_done;   // the first read after reset has been checked.
    bit flush_seen;       // a flush was driven in the previous cycle.

    function automatic string test_name(input int id);
        case (id)
            1:       return "straight_run";
            2:       return "mixed_length";
            3:       return "refill_and_stall";
            4:       return "flush_mid_bundle";
            5:       return "flush_redirect";
            default: return "reset_state";
        endcase
    endfunction

    always @(posedge clk_i) begin : edge_tracker
        seen_edge <= 1'b1;
    end : edge_tracker

    // outputs settle long before the falling edge, so sampling there is race free.
    always @(negedge clk_i) begin : compare_outputs
        if (!rst_n_i) begin
            if (seen_edge && (instr_valid_i !== 1'b0)) begin
                $display("instr_valid_o was high while reset was asserted.");
                failure_count_o++;
            end
            if (seen_edge && (mem_req_i !== 1'b0)) begin
                $display("mem_req_o was high while reset was asserted.");
                failure_count_o++;
            end
        end else begin
            if (flush_seen && (instr_valid_i !== 1'b0)) begin
                $display("instr_valid_o stayed high in the cycle after a flush.");
                failure_count_o++;
            end
            if ((mem_req_i === 1'b1) && !first_req_done) begin
                first_req_done = 1'b1;
                if (mem_addr_i !== BOOT_PC) begin
                    $display("MISMATCH test=%s first mem_addr expected=%h actual=%h",
                             test_name(0), BOOT_PC, mem_addr_i);
                    mismatch_count_o++;
                end
            end
            if ((instr_valid_i === 1'b1) && (stall_i === 1'b0) && (accepted_o < exp_count_i)) begin
                if (pc_i !== exp_pc_i[accepted_o]) begin
                    $display("MISMATCH test=%s index=%0d pc expected=%h actual=%h",
                             test_name(exp_test_i[accepted_o]), accepted_o,
                             exp_pc_i[accepted_o], pc_i);
                    mismatch_count_o++;
                end
                if (instr_i !== exp_instr_i[accepted_o]) begin
                    $display("MISMATCH test=%s index=%0d instr expected=%h actual=%h",
                             test_name(exp_test_i[accepted_o]), accepted_o,
                             exp_instr_i[accepted_o], instr_i);
                    mismatch_count_o++;
                end
                accepted_o++;                  // this instruction leaves on the next edge.
            end
        end
        flush_seen = rst_n_i && (flush_i === 1'b1);
    end : compare_outputs

endmodule : fetch_checker

/* verif/fetch_unit_tb.sv */
`timescale 1ns/10ps

module fetch_unit_tb;
    import fetch_pkg::*;

    localparam int    BUFFER_SIZE   = 8;
    localparam int    REQUEST_LIMIT = 4;
    localparam addr_t BOOT_PC       = 32'h0000_0000;
    localparam int    MAX_EXP       = 64;
    localparam int    MAX_CMD       = 16;
    localparam int    MEM_WORDS     = 256;       // 1 KiB of instruction memory.

    logic                     clk_i;
    logic                     rst_n_i;
    logic                     stall_i;
    logic                     flush_i;
    addr_t                    redirect_pc_i;
    logic                     mem_req_o;
    addr_t                    mem_addr_o;
    logic                     mem_valid_i = 1'b0;
    instr_t [BUFFER_SIZE-1:0] mem_bundle_i = '0;
    instr_t                   instr_o;
    addr_t                    pc_o;
    logic                     instr_valid_o;

    instr_t      mem [MEM_WORDS];
    addr_t       exp_pc [MAX_EXP];
    instr_t      exp_instr [MAX_EXP];
    int          exp_test [MAX_EXP];
    int          exp_count;
    byte         cmd_kind [MAX_CMD];     // S for a stall, F for a flush.
    int          cmd_idx [MAX_CMD];      // instruction index at which the command starts.
    logic [31:0] cmd_arg [MAX_CMD];      // stall length in cycles or redirect address.
    int          cmd_count;
    int          accepted;
    int          mismatch_count;
    int          failure_count;
    int          tb_errors;
    int          seed;
    int          cycle_limit;
    logic        req_seen;
    addr_t       req_addr;
    addr_t       pend_addr;
    int          wait_left;              // cycles until the pending read answers.

    fetch_unit #(
        .BUFFER_SIZE   (BUFFER_SIZE),
        .REQUEST_LIMIT (REQUEST_LIMIT),
        .BOOT_PC       (BOOT_PC)
    ) DUT (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .stall_i       (stall_i),
        .flush_i       (flush_i),
        .redirect_pc_i (redirect_pc_i),
        .mem_req_o     (mem_req_o),
        .mem_addr_o    (mem_addr_o),
        .mem_valid_i   (mem_valid_i),
        .mem_bundle_i  (mem_bundle_i),
        .instr_o       (instr_o),
        .pc_o          (pc_o),
        .instr_valid_o (instr_valid_o)
    );

    fetch_checker #(
        .BOOT_PC          (BOOT_PC),
        .MAX_EXP          (MAX_EXP)
    ) u_fetch_checker (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .stall_i          (stall_i),
        .flush_i          (flush_i),
        .instr_valid_i    (instr_valid_o),
        .instr_i          (instr_o),
        .pc_i             (pc_o),
        .mem_req_i        (mem_req_o),
        .mem_addr_i       (mem_addr_o),
        .exp_pc_i         (exp_pc),
        .exp_instr_i      (exp_instr),
        .exp_test_i       (exp_test),
        .exp_count_i      (exp_count),
        .accepted_o       (accepted),
        .mismatch_count_o (mismatch_count),
        .failure_count_o  (failure_count)
    );

    always #50 clk_i = ~clk_i;    // 100 ns period.

    task automatic load_vectors();
        int     fd;
        int     n;
        int     t;
        string  line;
        byte    tag;
        addr_t  a;
        instr_t w [8];
        fd = $fopen("verif/fetch_vectors.txt", "r");
        if (fd == 0) begin
            $display("could not open the vectors file verif/fetch_vectors.txt.");
            tb_errors++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (line.len() == 0) begin
                continue;
            end
            tag = line.getc(0);
            case (tag)
                "M": begin
                    n = $sscanf(line, "M %h %h %h %h %h %h %h %h %h",
                                a, w[0], w[1], w[2], w[3], w[4], w[5], w[6], w[7]);
                    for (int i = 0; i < 8; i++) begin
                        mem[a[9:2] + 8'(i)] = w[i];      // one bundle of eight words per line.
                    end
                end
                "E": begin
                    n = $sscanf(line, "E %d %h %h", t, a, w[0]);
                    exp_test[exp_count]  = t;
                    exp_pc[exp_count]    = a;
                    exp_instr[exp_count] = w[0];
                    exp_count++;
                end
                "S": begin
                    n = $sscanf(line, "S %d %d", cmd_idx[cmd_count], cmd_arg[cmd_count]);
                    cmd_kind[cmd_count] = tag;
                    cmd_count++;
                end
                "F": begin
                    n = $sscanf(line, "F %d %h", cmd_idx[cmd_count], cmd_arg[cmd_count]);
                    cmd_kind[cmd_count] = tag;
                    cmd_count++;
                end
                default: begin
                end
            endcase
        end
        $fclose(fd);
    endtask

    task automatic finish_run(input bit timed_out);
        int total;
        total = mismatch_count + failure_count + tb_errors + int'(timed_out);
        $display("errors: %0d mismatches, %0d other failures, %0d setup errors, %0d of %0d checked",
                 mismatch_count, failure_count + int'(timed_out), tb_errors, accepted, exp_count);
        if (total == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    endtask

    // reads are sampled on the falling edge, where mem_req_o is stable.
    always @(negedge clk_i) begin : sample_request
        req_seen = rst_n_i && (mem_req_o === 1'b1);  // memory ignores requests during reset.
        req_addr = mem_addr_o;
    end : sample_request

    always @(posedge clk_i) begin : answer_reads
        #1;
        mem_valid_i = 1'b0;
        if (req_seen) begin
            wait_left = 1 + int'($unsigned($random(seed)) % 4);  // 1 to 4 cycles of latency.
            pend_addr = req_addr;
        end
        if (wait_left > 0) begin
            wait_left--;
            if (wait_left == 0) begin
                mem_valid_i = 1'b1;
                for (int i = 0; i < BUFFER_SIZE; i++) begin
                    mem_bundle_i[i] = mem[pend_addr[9:2] + 8'(i)];
                end
            end
        end
    end : answer_reads

    initial begin : watchdog
        int cycle_count;
        cycle_count = 0;
        wait (cycle_limit > 0);
        while (cycle_count < cycle_limit) begin
            @(posedge clk_i);
            cycle_count++;
        end
        $display("timeout: the expected instruction stream did not complete in %0d cycles.",
                 cycle_limit);
        finish_run(1'b1);
    end : watchdog

    initial begin : main_sequence
        clk_i         = 1'b0;
        rst_n_i       = 1'b0;
        stall_i       = 1'b0;
        flush_i       = 1'b0;
        redirect_pc_i = '0;
        seed          = 32'h4d4c8730;
        wait_left     = 0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = (32'(i) * 32'h9e37_79b9) ^ 32'h5a5a_0000;  // background never matches code.
        end
        load_vectors();
        cycle_limit = 20 * exp_count + 200;
        repeat (5) @(posedge clk_i);
        #1;
        rst_n_i = 1'b1;
        for (int c = 0; c < cmd_count; c++) begin
            while (accepted < cmd_idx[c]) begin
                @(posedge clk_i);
                #1;
            end
            if (cmd_kind[c] == "S") begin
                stall_i = 1'b1;
                repeat (cmd_arg[c]) begin
                    @(posedge clk_i);
                    #1;
                end
                stall_i = 1'b0;
            end else begin
                stall_i       = 1'b1;            // the flushed instruction is not taken.
                flush_i       = 1'b1;
                redirect_pc_i = cmd_arg[c];
                @(posedge clk_i);
                #1;
                flush_i = 1'b0;
                stall_i = 1'b0;
            end
        end
        while (accepted < exp_count) begin
            @(posedge clk_i);
            #1;
        end
        finish_run(1'b0);
    end : main_sequence

endmodule : fetch_unit_tb

/* verif/fetch_vectors.txt */
# M <bundle byte address> <word0> ... <word7>    E <test id> <pc> <instr>
# S <instr index> <stall cycles>    F <instr index> <redirect pc>
M 00000000 00100093 00200113 00300193 00400213 00500293 00600313 00700393 00800413
M 00000020 05134501 050500a0 56934082 00131234 8082cafe 0badf00f 00008067 47810001
M 00000040 40400013 44400013 48400013 4c400013 50500013 54500013 58500013 5c500013
M 00000060 bad1bad0 bad3bad2 8593bad4 040500c5 fe0718e3 00b50023 45058526 00e7a023
S 22 5
S 26 1
F 26 0000006a
F 29 00000026
# straight run of 32-bit instructions
E 1 00000000 00100093
E 1 00000004 00200113
E 1 00000008 00300193
E 1 0000000c 00400213
E 1 00000010 00500293
E 1 00000014 00600313
E 1 00000018 00700393
E 1 0000001c 00800413
# mixed 16-bit and 32-bit
E 2 00000020 00004501
E 2 00000022 00a00513
E 2 00000026 00000505
E 2 00000028 00004082
E 2 0000002a 12345693
E 2 0000002e cafe0013
E 2 00000032 00008082
E 2 00000034 0badf00f
E 2 00000038 00008067
E 2 0000003c 00000001
E 2 0000003e 00004781
# refill with a stall in the middle
E 3 00000040 40400013
E 3 00000044 44400013
E 3 00000048 48400013
E 3 0000004c 4c400013
E 3 00000050 50500013
E 3 00000054 54500013
E 3 00000058 58500013
# flush into the middle of a bundle while the prefetch is out
E 4 0000006a 00c58593
E 4 0000006e 00000405
E 4 00000070 fe0718e3
# flush back into an earlier bundle
E 5 00000026 00000505
E 5 00000028 00004082
E 5 0000002a 12345693
E 5 0000002e cafe0013
E 5 00000032 00008082
E 5 00000034 0badf00f
E 5 00000038 00008067
E 5 0000003c 00000001
E 5 0000003e 00004781

/* compile.f */
rtl/fetch_pkg.sv
rtl/fetch_bundle_if.sv
rtl/bundle_fetcher.sv
rtl/instruction_buffer.sv
rtl/instr_length_decoder.sv
rtl/fetch_unit.sv
verif/fetch_checker.sv
verif/fetch_unit_tb.sv

/* run_sim.sh */
#!/bin/sh
# builds and runs the fetch unit testbench, then checks the log for a failure.
verilator --binary --timing --top-module fetch_unit_tb -f compile.f -Mdir obj_dir -o fetch_sim \
    > build.log 2>&1 \
    && ./obj_dir/fetch_sim > sim.log 2>&1 \
    || { cat build.log; echo "RESULT: FAIL" >> sim.log; }
cat sim.log
grep -q "RESULT: FAIL" sim.log && exit 1 || exit 0
